// File: dec_pkg.sv
package dec_pkg;

  // ----------------------------------------------------------------------
  // widths
  // ----------------------------------------------------------------------

  localparam int cLLR_W    = 4;  // one soft metric
  localparam int cBEAT_LLR = 4;  // llrs per input beat
  localparam int cCHK_LEN  = 8;  // llrs per parity group
  localparam int cTAG_W    = 4;  // frame tag
  localparam int cERR_W    = 8;  // flipped bits per frame

  // ----------------------------------------------------------------------
  // types
  // ----------------------------------------------------------------------

  typedef logic signed [cLLR_W-1:0] llr_t;
  typedef llr_t        [cCHK_LEN-1:0] grp_llr_t;  // one input buffer word
  typedef logic        [cCHK_LEN-2:0] dat_t;      // parity bit dropped
  typedef logic        [cTAG_W-1:0]   tag_t;
  typedef logic        [cERR_W-1:0]   err_t;

  typedef struct packed {
    logic                        sop;
    logic                        eop;
    tag_t                        tag;  // valid on sop only
    llr_t [cBEAT_LLR-1:0]        llr;  // llr[0] is the earliest
  } in_beat_t;

  typedef struct packed {
    logic sop;
    logic eop;
    tag_t tag;
    dat_t dat;
    logic decfail;  // tie on a failing group somewhere in the frame
    err_t err;      // flips in the whole frame
  } out_beat_t;

  // per bank frame info of the output buffer
  typedef struct packed {
    tag_t tag;
    logic decfail;
    err_t err;
  } obuf_tag_t;

endpackage

// File: dec_source.sv
module dec_source #(
  parameter int pCHK_NUM          = 4,
  parameter bit pDO_LLR_INVERSION = 1
) (
  input  logic                        iclkin,
  input  logic                        rst_n,
  // input stream
  input  dec_pkg::in_beat_t           in_beat,
  input  logic                        in_valid,
  output logic                        in_ready,
  // input buffer write side
  input  logic                        wr_avail,
  output logic                        wr_en,
  output logic [$clog2(pCHK_NUM)-1:0] wr_addr,
  output dec_pkg::grp_llr_t           wr_data,
  output logic                        wr_done,
  output dec_pkg::tag_t               wr_tag
);

  import dec_pkg::*;

  localparam int   cAW      = $clog2(pCHK_NUM);
  localparam llr_t cLLR_MIN = llr_t'({1'b1, {(cLLR_W-1){1'b0}}});  // -8
  localparam llr_t cLLR_MAX = llr_t'({1'b0, {(cLLR_W-1){1'b1}}});  // +7

  llr_t [cBEAT_LLR-1:0] beat_llr;  // beat after optional inversion
  llr_t [cBEAT_LLR-1:0] half_q;    // first half of the group word
  logic                 second_q;  // next beat closes a group
  logic                 frame_q;   // sop seen, eop not yet
  logic                 rdy_en_q;  // low only straight out of reset
  logic [cAW-1:0]       addr_q;    // group index inside the bank
  tag_t                 tag_q;
  logic                 xfer;

  // negate with saturation, -8 has no positive twin
  function automatic llr_t inv_llr(llr_t v);
    return (v == cLLR_MIN) ? cLLR_MAX : -v;
  endfunction

  always_comb begin
    for (int i = 0; i < cBEAT_LLR; i++) begin
      beat_llr[i] = pDO_LLR_INVERSION ? inv_llr(in_beat.llr[i]) : in_beat.llr[i];
    end
  end

  // a frame may only start into a free bank, then runs to its end
  assign in_ready = rdy_en_q & (frame_q | wr_avail);
  assign xfer     = in_valid & in_ready;

  assign wr_en   = xfer & second_q;          // second beat completes the word
  assign wr_addr = addr_q;
  assign wr_data = {beat_llr, half_q};       // first beat in the low llrs
  assign wr_done = wr_en & in_beat.eop;      // closes the bank
  assign wr_tag  = tag_q;

  always_ff @(posedge iclkin or negedge rst_n) begin
    if (!rst_n) begin
      rdy_en_q <= 1'b0;
      second_q <= 1'b0;
      frame_q  <= 1'b0;
      addr_q   <= '0;
    end else begin
      rdy_en_q <= 1'b1;
      if (xfer) begin
        second_q <= ~second_q;
        if (in_beat.sop) frame_q <= 1'b1;
        if (wr_en)       addr_q  <= addr_q + 1'b1;
        if (wr_done) begin
          frame_q <= 1'b0;
          addr_q  <= '0;  // next frame from group 0
        end
      end
    end
  end

  // payload
  always_ff @(posedge iclkin) begin
    if (xfer & ~second_q)  half_q <= beat_llr;
    if (xfer & in_beat.sop) tag_q <= in_beat.tag;
  end

endmodule

// File: dec_bank_buffer.sv
module dec_bank_buffer #(
  parameter int pWORD_W  = 32,
  parameter int pTAG_W   = 4,
  parameter int pCHK_NUM = 4
) (
  input  logic                        iclkin,
  input  logic                        rst_n,
  // write side
  input  logic                        wr_en,
  input  logic [$clog2(pCHK_NUM)-1:0] wr_addr,
  input  logic [pWORD_W-1:0]          wr_data,
  input  logic                        wr_done,
  input  logic [pTAG_W-1:0]           wr_tag,
  output logic                        wr_avail,
  // read side
  input  logic [$clog2(pCHK_NUM)-1:0] rd_addr,
  output logic [pWORD_W-1:0]          rd_data,
  output logic [pTAG_W-1:0]           rd_tag,
  input  logic                        rd_done,
  output logic                        rd_avail
);

  // ----------------------------------------------------------------------
  // storage
  // ----------------------------------------------------------------------

  logic [pWORD_W-1:0] mem_q [2][pCHK_NUM];  // ping-pong banks
  logic [pTAG_W-1:0]  tag_q [2];            // one tag per bank

  logic [1:0] full_q;     // bank holds a complete frame
  logic       wr_bank_q;  // bank being filled
  logic       rd_bank_q;  // bank being drained

  always_ff @(posedge iclkin) begin
    if (wr_en)   mem_q[wr_bank_q][wr_addr] <= wr_data;
    if (wr_done) tag_q[wr_bank_q]          <= wr_tag;
    rd_data <= mem_q[rd_bank_q][rd_addr];   // 1 tick read
  end

  // tag is static while the bank is held
  assign rd_tag = tag_q[rd_bank_q];

  // ----------------------------------------------------------------------
  // bank flags
  // ----------------------------------------------------------------------

  assign wr_avail = ~full_q[wr_bank_q];
  assign rd_avail =  full_q[rd_bank_q];

  always_ff @(posedge iclkin or negedge rst_n) begin
    if (!rst_n) begin
      full_q    <= '0;
      wr_bank_q <= 1'b0;
      rd_bank_q <= 1'b0;
    end else begin
      if (wr_done) wr_bank_q <= ~wr_bank_q;
      if (rd_done) rd_bank_q <= ~rd_bank_q;
      // writer only owns empty banks, reader only full ones
      for (int b = 0; b < 2; b++) begin
        if (wr_done && wr_bank_q == 1'(b)) begin
          full_q[b] <= 1'b1;
        end else if (rd_done && rd_bank_q == 1'(b)) begin
          full_q[b] <= 1'b0;
        end
      end
    end
  end

endmodule

// File: dec_spc_engine.sv
module dec_spc_engine #(
  parameter int pCHK_NUM = 4
) (
  input  logic                        iclkin,
  input  logic                        rst_n,
  // input buffer side
  input  logic                        in_avail,
  output logic [$clog2(pCHK_NUM)-1:0] in_addr,
  input  dec_pkg::grp_llr_t           in_data,
  input  dec_pkg::tag_t               in_tag,
  output logic                        in_done,
  // output buffer side
  input  logic                        out_avail,
  output logic                        out_en,
  output logic [$clog2(pCHK_NUM)-1:0] out_addr,
  output dec_pkg::dat_t               out_data,
  output dec_pkg::obuf_tag_t          out_tag,
  output logic                        out_done
);

  import dec_pkg::*;

  localparam int             cAW    = $clog2(pCHK_NUM);
  localparam int             cIDX_W = $clog2(cCHK_LEN);
  localparam logic [cAW-1:0] cLAST  = cAW'(pCHK_NUM - 1);

  typedef enum logic [1:0] {idle, run, flush} state_t;

  state_t         state_q;
  logic [cAW-1:0] rd_cnt_q;               // read address issued
  logic [cAW-1:0] rd_addr_q, wr_addr_q;   // address travelling with data
  logic           rd_vld_q, wr_vld_q;
  dat_t           wr_dat_q;
  err_t           err_q;
  logic           fail_q;

  logic [cCHK_LEN-1:0] hard, fixed;
  logic [cLLR_W-1:0]   mag [cCHK_LEN];   // unsigned, -8 gives 8
  logic [cLLR_W-1:0]   min_mag;
  logic [cIDX_W-1:0]   min_idx;
  logic                min_tie, par_err;

  // ----------------------------------------------------------------------
  // wagner decode of one group
  // ----------------------------------------------------------------------

  always_comb begin
    for (int i = 0; i < cCHK_LEN; i++) begin
      hard[i] = in_data[i][cLLR_W-1];                    // sign is the bit
      mag[i]  = hard[i] ? -in_data[i] : in_data[i];
    end
    min_mag = mag[0];
    min_idx = '0;
    min_tie = 1'b0;
    for (int i = 1; i < cCHK_LEN; i++) begin
      if (mag[i] < min_mag) begin                        // strict, low index wins
        min_mag = mag[i];
        min_idx = cIDX_W'(i);
        min_tie = 1'b0;
      end else if (mag[i] == min_mag) begin
        min_tie = 1'b1;
      end
    end
    par_err = ^hard;                                     // even parity expected
    fixed   = hard;
    if (par_err) fixed[min_idx] = ~hard[min_idx];
  end

  // ----------------------------------------------------------------------
  // fsm and bookkeeping
  // ----------------------------------------------------------------------

  always_ff @(posedge iclkin or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= idle;
      rd_cnt_q <= '0;
      rd_vld_q <= 1'b0;
      wr_vld_q <= 1'b0;
      err_q    <= '0;
      fail_q   <= 1'b0;
    end else begin
      rd_vld_q <= (state_q == run);   // data back next tick
      wr_vld_q <= rd_vld_q;
      case (state_q)
        idle : if (in_avail & out_avail) begin
          state_q  <= run;
          rd_cnt_q <= '0;
          err_q    <= '0;
          fail_q   <= 1'b0;
        end
        run : begin
          rd_cnt_q <= rd_cnt_q + 1'b1;
          if (rd_cnt_q == cLAST) state_q <= flush;
        end
        flush : if (out_done) state_q <= idle;  // pipe drained
        default : state_q <= idle;
      endcase
      if (rd_vld_q) begin
        err_q  <= err_q + err_t'(par_err);
        fail_q <= fail_q | (par_err & min_tie);
      end
    end
  end

  always_ff @(posedge iclkin) begin
    rd_addr_q <= rd_cnt_q;
    wr_addr_q <= rd_addr_q;
    wr_dat_q  <= fixed[cCHK_LEN-2:0];   // parity bit stays behind
  end

  assign in_addr  = rd_cnt_q;
  assign out_en   = wr_vld_q;
  assign out_addr = wr_addr_q;
  assign out_data = wr_dat_q;
  assign out_done = wr_vld_q & (wr_addr_q == cLAST);  // last write closes both banks
  assign in_done  = out_done;
  assign out_tag  = '{tag: in_tag, decfail: fail_q, err: err_q};

endmodule

// File: dec_sink.sv
module dec_sink #(
  parameter int pCHK_NUM = 4
) (
  input  logic                        iclkin,
  input  logic                        rst_n,
  // output buffer read side
  input  logic                        rd_avail,
  output logic [$clog2(pCHK_NUM)-1:0] rd_addr,
  input  dec_pkg::dat_t               rd_data,
  input  dec_pkg::obuf_tag_t          rd_tag,
  output logic                        rd_done,
  // output stream
  output dec_pkg::out_beat_t          out_beat,
  output logic                        out_valid,
  input  logic                        out_ready
);

  import dec_pkg::*;

  localparam int             cAW   = $clog2(pCHK_NUM);
  localparam logic [cAW-1:0] cLAST = cAW'(pCHK_NUM - 1);

  logic           active_q, iss_all_q;   // bank owned, all reads issued
  logic           rd_vld_q, skid_vld_q;
  logic [cAW-1:0] rd_cnt_q, rd_idx_q;
  logic [1:0]     level;                 // out + skid + in flight
  logic           pop, issue;
  out_beat_t      arr_beat, skid_q;

  assign pop   = out_valid & out_ready;
  assign level = 2'(out_valid) + 2'(skid_vld_q) + 2'(rd_vld_q);
  // never more than two beats owed, so the skid cannot overflow
  assign issue = active_q & ~iss_all_q & ((level < 2'd2) | ((level == 2'd2) & pop));

  assign rd_addr = rd_cnt_q;
  assign rd_done = rd_vld_q & (rd_idx_q == cLAST);  // tag still valid this tick

  assign arr_beat = '{sop: (rd_idx_q == '0), eop: (rd_idx_q == cLAST), tag: rd_tag.tag,
                      dat: rd_data, decfail: rd_tag.decfail, err: rd_tag.err};

  always_ff @(posedge iclkin or negedge rst_n) begin
    if (!rst_n) begin
      active_q   <= 1'b0;
      iss_all_q  <= 1'b0;
      rd_cnt_q   <= '0;
      rd_vld_q   <= 1'b0;
      skid_vld_q <= 1'b0;
      out_valid  <= 1'b0;
    end else begin
      rd_vld_q <= issue;
      if (!active_q) begin
        if (rd_avail) begin
          active_q  <= 1'b1;
          iss_all_q <= 1'b0;
          rd_cnt_q  <= '0;
        end
      end else begin
        if (issue) begin
          rd_cnt_q <= rd_cnt_q + 1'b1;
          if (rd_cnt_q == cLAST) iss_all_q <= 1'b1;
        end
        if (rd_done) active_q <= 1'b0;
      end
      if (pop | ~out_valid) begin
        out_valid  <= skid_vld_q | rd_vld_q;
        skid_vld_q <= skid_vld_q & rd_vld_q;  // skid refilled by the arrival
      end else if (rd_vld_q) begin
        skid_vld_q <= 1'b1;                   // stalled, park it
      end
    end
  end

  // payload path
  always_ff @(posedge iclkin) begin
    if (issue) rd_idx_q <= rd_cnt_q;
    if (pop | ~out_valid) begin
      if (skid_vld_q) begin
        out_beat <= skid_q;
        if (rd_vld_q) skid_q <= arr_beat;
      end else begin
        out_beat <= arr_beat;
      end
    end else if (rd_vld_q) begin
      skid_q <= arr_beat;
    end
  end

endmodule

// File: dec_top.sv
module dec_top #(
  parameter int pCHK_NUM          = 4,  // groups per frame, 2 or more
  parameter bit pDO_LLR_INVERSION = 1
) (
  input  logic                iclkin,
  input  logic                rst_n,
  input  dec_pkg::in_beat_t   in_beat,
  input  logic                in_valid,
  output logic                in_ready,
  output dec_pkg::out_beat_t  out_beat,
  output logic                out_valid,
  input  logic                out_ready
);

  import dec_pkg::*;

  localparam int cAW = $clog2(pCHK_NUM);

  // source -> input buffer
  logic           src_wr_en, src_wr_done, ibuf_wr_avail;
  logic [cAW-1:0] src_wr_addr;
  grp_llr_t       src_wr_data;
  tag_t           src_wr_tag;
  // input buffer -> engine
  logic           ibuf_rd_avail, eng_in_done;
  logic [cAW-1:0] eng_in_addr;
  grp_llr_t       ibuf_rd_data;
  tag_t           ibuf_rd_tag;
  // engine -> output buffer
  logic           obuf_wr_avail, eng_out_en, eng_out_done;
  logic [cAW-1:0] eng_out_addr;
  dat_t           eng_out_data;
  obuf_tag_t      eng_out_tag;
  // output buffer -> sink
  logic           obuf_rd_avail, snk_rd_done;
  logic [cAW-1:0] snk_rd_addr;
  dat_t           obuf_rd_data;
  obuf_tag_t      obuf_rd_tag;

  // ----------------------------------------------------------------------
  // input side
  // ----------------------------------------------------------------------

  dec_source #(.pCHK_NUM(pCHK_NUM), .pDO_LLR_INVERSION(pDO_LLR_INVERSION)) u_src (
    .iclkin (iclkin), .rst_n (rst_n),
    .in_beat (in_beat), .in_valid (in_valid), .in_ready (in_ready),
    .wr_avail (ibuf_wr_avail), .wr_en (src_wr_en), .wr_addr (src_wr_addr),
    .wr_data (src_wr_data), .wr_done (src_wr_done), .wr_tag (src_wr_tag)
  );

  dec_bank_buffer #(.pWORD_W($bits(grp_llr_t)), .pTAG_W($bits(tag_t)),
                    .pCHK_NUM(pCHK_NUM)) u_ibuf (
    .iclkin (iclkin), .rst_n (rst_n),
    .wr_en (src_wr_en), .wr_addr (src_wr_addr), .wr_data (src_wr_data),
    .wr_done (src_wr_done), .wr_tag (src_wr_tag), .wr_avail (ibuf_wr_avail),
    .rd_addr (eng_in_addr), .rd_data (ibuf_rd_data), .rd_tag (ibuf_rd_tag),
    .rd_done (eng_in_done), .rd_avail (ibuf_rd_avail)
  );

  // ----------------------------------------------------------------------
  // decoder core and output side
  // ----------------------------------------------------------------------

  dec_spc_engine #(.pCHK_NUM(pCHK_NUM)) u_eng (
    .iclkin (iclkin), .rst_n (rst_n),
    .in_avail (ibuf_rd_avail), .in_addr (eng_in_addr), .in_data (ibuf_rd_data),
    .in_tag (ibuf_rd_tag), .in_done (eng_in_done),
    .out_avail (obuf_wr_avail), .out_en (eng_out_en), .out_addr (eng_out_addr),
    .out_data (eng_out_data), .out_tag (eng_out_tag), .out_done (eng_out_done)
  );

  dec_bank_buffer #(.pWORD_W($bits(dat_t)), .pTAG_W($bits(obuf_tag_t)),
                    .pCHK_NUM(pCHK_NUM)) u_obuf (
    .iclkin (iclkin), .rst_n (rst_n),
    .wr_en (eng_out_en), .wr_addr (eng_out_addr), .wr_data (eng_out_data),
    .wr_done (eng_out_done), .wr_tag (eng_out_tag), .wr_avail (obuf_wr_avail),
    .rd_addr (snk_rd_addr), .rd_data (obuf_rd_data), .rd_tag (obuf_rd_tag),
    .rd_done (snk_rd_done), .rd_avail (obuf_rd_avail)
  );

  dec_sink #(.pCHK_NUM(pCHK_NUM)) u_snk (
    .iclkin (iclkin), .rst_n (rst_n),
    .rd_avail (obuf_rd_avail), .rd_addr (snk_rd_addr), .rd_data (obuf_rd_data),
    .rd_tag (obuf_rd_tag), .rd_done (snk_rd_done),
    .out_beat (out_beat), .out_valid (out_valid), .out_ready (out_ready)
  );

endmodule

// File: tb_dec_assert.sv
module dec_top_assert (
  input logic               iclkin,
  input logic               rst_n,
  input logic               in_valid,
  input logic               in_ready,
  input dec_pkg::out_beat_t out_beat,
  input logic               out_valid,
  input logic               out_ready
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;  // failures seen so far

  // stalled beat must hold, valid and payload
  a_out_hold : assert property (@(posedge iclkin) disable iff (!rst_n)
      out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else begin
      fail_cnt++;
      $error("output beat changed or dropped while stalled");
    end

  // nothing moves in reset
  a_in_rst : assert property (@(posedge iclkin) !rst_n |-> !(in_valid && in_ready))
    else begin
      fail_cnt++;
      $error("input beat accepted during reset");
    end

  a_out_rst : assert property (@(posedge iclkin) !rst_n |-> !(out_valid && out_ready))
    else begin
      fail_cnt++;
      $error("output beat sent during reset");
    end

  a_out_known : assert property (@(posedge iclkin) disable iff (!rst_n)
      out_valid |-> !$isunknown(out_beat))
    else begin
      fail_cnt++;
      $error("output beat has unknown bits while valid");
    end

endmodule

bind dec_top dec_top_assert u_assert (
  .iclkin (iclkin), .rst_n (rst_n), .in_valid (in_valid), .in_ready (in_ready),
  .out_beat (out_beat), .out_valid (out_valid), .out_ready (out_ready)
);

// File: tb_dec.sv
module tb_dec;

  timeunit 1ns;
  timeprecision 100ps;

  import dec_pkg::*;

  localparam int cCHK_NUM  = 4;
  localparam bit cINV      = 1'b1;
  localparam int cFRAMES   = 40;
  localparam int cBEATS_IN = 2 * cCHK_NUM;                  // two beats per group
  localparam int cWATCH_NS = cFRAMES * cBEATS_IN * 4 * 10;  // generous bound

  typedef llr_t frame_t [cCHK_NUM][cCHK_LEN];  // llrs as sent, before inversion

  logic      iclkin, rst_n;
  in_beat_t  in_beat;
  logic      in_valid, in_ready;
  out_beat_t out_beat;
  logic      out_valid, out_ready;

  out_beat_t exp_q [$];  // expected output beats, oldest first

  dec_top #(.pCHK_NUM(cCHK_NUM), .pDO_LLR_INVERSION(cINV)) u_dut (
    .iclkin (iclkin), .rst_n (rst_n),
    .in_beat (in_beat), .in_valid (in_valid), .in_ready (in_ready),
    .out_beat (out_beat), .out_valid (out_valid), .out_ready (out_ready)
  );

  always #2 iclkin = ~iclkin;  // 4 ns period

  // ----------------------------------------------------------------------
  // reference model and frame builder
  // ----------------------------------------------------------------------

  // wagner decode per group, frame totals on every beat
  function automatic void ref_frame(input frame_t f, input tag_t tag);
    int                  v, m, min_m, min_i, n_min, ones;
    logic [cCHK_LEN-1:0] bits;
    dat_t                dat [cCHK_NUM];
    err_t                err;
    logic                fail;
    out_beat_t           b;
    err  = '0;
    fail = 1'b0;
    for (int g = 0; g < cCHK_NUM; g++) begin
      ones  = 0;
      min_m = 99;
      min_i = 0;
      n_min = 0;
      for (int i = 0; i < cCHK_LEN; i++) begin
        v = cINV ? -int'(f[g][i]) : int'(f[g][i]);
        if (v > 7) v = 7;             // +8 does not fit
        bits[i] = (v < 0);            // negative means a one
        m = (v < 0) ? -v : v;
        if (bits[i]) ones++;
        if (m < min_m) begin
          min_m = m;
          min_i = i;
          n_min = 1;
        end else if (m == min_m) begin
          n_min++;
        end
      end
      if (ones % 2 == 1) begin        // odd parity, flip the weakest
        bits[min_i] = ~bits[min_i];
        err = err + 1'b1;
        if (n_min > 1) fail = 1'b1;
      end
      dat[g] = bits[cCHK_LEN-2:0];
    end
    for (int g = 0; g < cCHK_NUM; g++) begin
      b = '{sop: (g == 0), eop: (g == cCHK_NUM - 1), tag: tag, dat: dat[g],
            decfail: fail, err: err};
      exp_q.push_back(b);
    end
  endfunction

  // mode 0 clean, 1 one weak wrong sign, 2 same plus a tie, 3 raw random
  function automatic void make_frame(input int mode, output frame_t f);
    llr_t x;
    bit   par;
    int   pos, pos2;
    for (int g = 0; g < cCHK_NUM; g++) begin
      par = 1'b0;
      for (int i = 0; i < cCHK_LEN - 1; i++) begin
        x = llr_t'($urandom_range(7, 3));
        if ($urandom_range(1) != 0) x = -x;
        if (mode == 3) x = llr_t'($urandom_range(15));  // -8 included
        par ^= cINV ? (x > 0) : (x < 0);
        f[g][i] = x;
      end
      x = ((par == 1'b1) == cINV) ? llr_t'(4) : llr_t'(-4);  // evens out the group
      f[g][cCHK_LEN-1] = (mode == 3) ? llr_t'($urandom_range(15)) : x;
      if (mode == 1 || mode == 2) begin
        pos = int'($urandom_range(cCHK_LEN - 1));
        f[g][pos] = (f[g][pos] > 0) ? llr_t'(-1) : llr_t'(1);
        if (mode == 2) begin
          pos2 = (pos + 1 + int'($urandom_range(cCHK_LEN - 2))) % cCHK_LEN;
          f[g][pos2] = (f[g][pos2] > 0) ? llr_t'(1) : llr_t'(-1);  // equal weakness
        end
      end
    end
  endfunction

  task automatic stop_on_error();
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    assert (got === want) else begin
      $display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, want);
      stop_on_error();
    end
  endtask

  // random idle gap, then hold the beat until in_ready
  task automatic send_beat(input in_beat_t b);
    logic taken;
    while ($urandom_range(3) == 0) begin
      in_valid = 1'b0;
      @(posedge iclkin);
      #0.5;
    end
    in_beat  = b;
    in_valid = 1'b1;
    taken    = 1'b0;
    while (!taken) begin
      @(negedge iclkin);
      taken = in_ready;  // settled mid cycle
      @(posedge iclkin);
      #0.5;
    end
    in_valid = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // processes
  // ----------------------------------------------------------------------

  initial begin : drive_in
    frame_t   f;
    tag_t     tag;
    in_beat_t b;
    int       mode;
    void'($urandom(34));
    iclkin    = 1'b0;
    rst_n     = 1'b0;
    in_beat   = '0;
    in_valid  = 1'b1;  // offered in reset, must be refused
    out_ready = 1'b0;
    repeat (2) @(posedge iclkin);
    #0.5;
    rst_n    = 1'b1;
    in_valid = 1'b0;
    for (int n = 0; n < cFRAMES; n++) begin
      mode = (n < 3) ? n : int'($urandom_range(3));  // directed first
      make_frame(mode, f);
      tag = tag_t'(n);
      ref_frame(f, tag);
      for (int k = 0; k < cBEATS_IN; k++) begin
        b.sop = (k == 0);
        b.eop = (k == cBEATS_IN - 1);
        b.tag = (k == 0) ? tag : tag_t'($urandom_range(15));  // junk off sop
        for (int j = 0; j < cBEAT_LLR; j++) begin
          b.llr[j] = f[k / 2][(k % 2) * cBEAT_LLR + j];
        end
        send_beat(b);
      end
    end
    while (exp_q.size() != 0) begin
      @(posedge iclkin);
    end
    repeat (20) @(posedge iclkin);  // room for a stray extra beat
    if (exp_q.size() == 0 && u_dut.u_assert.fail_cnt == 0) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      $display("bound assertions failed %0d times", u_dut.u_assert.fail_cnt);
      $display("ERRORS FOUND");
      $fatal(1, "run ended with failures");
    end
  end

  initial begin : drive_ready
    forever begin
      @(posedge iclkin);
      #0.5;
      out_ready = ($urandom_range(9) >= 3);  // low about 30 percent
    end
  end

  initial begin : compare_out
    out_beat_t want;
    forever begin
      @(negedge iclkin);
      if (rst_n && out_valid && out_ready) begin  // transfers on the next edge
        assert (exp_q.size() != 0) else begin
          $display("output beat arrived with no frame outstanding");
          stop_on_error();
        end
        want = exp_q.pop_front();
        check_value("out_beat.sop", 32'(out_beat.sop), 32'(want.sop));
        check_value("out_beat.eop", 32'(out_beat.eop), 32'(want.eop));
        check_value("out_beat.tag", 32'(out_beat.tag), 32'(want.tag));
        check_value("out_beat.dat", 32'(out_beat.dat), 32'(want.dat));
        check_value("out_beat.decfail", 32'(out_beat.decfail), 32'(want.decfail));
        check_value("out_beat.err", 32'(out_beat.err), 32'(want.err));
      end
    end
  end

  initial begin : watchdog
    #(cWATCH_NS);
    $display("timeout, decoder did not finish within %0d ns", cWATCH_NS);
    $display("ERRORS FOUND");
    $fatal(1, "simulation timed out");
  end

endmodule

// File: list.f
dec_pkg.sv
dec_source.sv
dec_bank_buffer.sv
dec_spc_engine.sv
dec_sink.sv
dec_top.sv
tb_dec_assert.sv
tb_dec.sv

// File: run.sh
#!/bin/sh
# build and run the decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/100ps -Wno-fatal -j 0 \
  --top-module tb_dec -f list.f -o sim_dec || exit 1
sim_out="$(./obj_dir/sim_dec 2>&1)"
echo "$sim_out"
echo "$sim_out" | grep -qx "NO ERRORS" && echo "run passed" || { echo "run failed"; exit 1; }
